// File: common/pool_pkg.sv
package pool_pkg;

    // ========================================
    // Datapath defaults
    // ========================================

    // Width of one activation lane
    localparam int ACT_WIDTH = 8;

    // Activations compared in parallel, power of two
    localparam int LANES = 8;

    // Point indices and memory addresses
    localparam int IDX_WIDTH = 16;

    // log2 of the largest neighbor count, cfg_k runs 1 to 2**MAP_WIDTH
    localparam int MAP_WIDTH = 5;

    // ========================================
    // Job configuration
    // ========================================

    // Channel count field
    localparam int CHN_WIDTH = 12;

    // Channel-group counter
    localparam int GRP_WIDTH = CHN_WIDTH - $clog2(LANES);

    // Job-last flag carried above the output address
    localparam int ATAG_WIDTH = 1;

    // ========================================
    // Sequencer states
    // ========================================

    // ST_IDLE   waiting for a job
    // ST_RUN    issuing one neighbor step per cycle
    // ST_DRAIN  waiting for the last write to be taken
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } pool_state_e;

endpackage

// File: pool_core/pool_seq.sv
`timescale 1ns/1ns

module pool_seq import pool_pkg::*; #(
    parameter int LANES     = pool_pkg::LANES,
    parameter int IDX_WIDTH = pool_pkg::IDX_WIDTH,
    parameter int MAP_WIDTH = pool_pkg::MAP_WIDTH
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            adv,
    input  logic                            cfg_vld,
    output logic                            cfg_rdy,
    input  logic [MAP_WIDTH:0]              cfg_k,
    input  logic [IDX_WIDTH-1:0]            cfg_nip,
    input  logic [CHN_WIDTH-1:0]            cfg_chn,
    output logic                            map_rd_en,
    output logic [IDX_WIDTH-1:0]            map_rd_addr,
    input  logic [IDX_WIDTH-1:0]            map_rd_dat,
    output logic                            ofm_rd_en,
    output logic [IDX_WIDTH-1:0]            ofm_rd_addr,
    output logic                            first_s2,
    output logic                            last_s2,
    output logic [IDX_WIDTH+ATAG_WIDTH-1:0] addr_s2,
    input  logic                            wr_done
);

    pool_state_e            state;

    // Captured job settings
    logic [MAP_WIDTH:0]     k_q;
    logic [IDX_WIDTH-1:0]   nip_q;
    logic [GRP_WIDTH-1:0]   grp_num_q;

    // Loop counters, point outermost
    logic [IDX_WIDTH-1:0]   pt_cnt;
    logic [GRP_WIDTH-1:0]   grp_cnt;
    logic [MAP_WIDTH-1:0]   nb_cnt;
    logic [IDX_WIDTH-1:0]   out_cnt;

    logic                   accept;
    logic                   step;
    logic                   nb_last;
    logic                   grp_last;
    logic                   pt_last;
    logic                   job_last;

    logic                   vld_s2;
    logic [GRP_WIDTH-1:0]   grp_s2;

    assign cfg_rdy  = (state == ST_IDLE);
    assign accept   = cfg_vld & cfg_rdy;
    assign step     = (state == ST_RUN) & adv;

    assign nb_last  = ({1'b0, nb_cnt} == k_q - 1'b1);
    assign grp_last = (grp_cnt == grp_num_q - 1'b1);
    assign pt_last  = (pt_cnt == nip_q - 1'b1);
    assign job_last = nb_last & grp_last & pt_last;

    // ========================================
    // Job FSM
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (accept) state <= ST_RUN;
                ST_RUN:   if (step && job_last) state <= ST_DRAIN;
                ST_DRAIN: if (wr_done) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_q       <= '0;
            nip_q     <= '0;
            grp_num_q <= '0;
        end else if (accept) begin
            k_q       <= cfg_k;
            nip_q     <= cfg_nip;
            grp_num_q <= GRP_WIDTH'(cfg_chn / LANES);
        end
    end

    // ========================================
    // Loop counters
    // ========================================

    // Output address runs sequentially since groups sit inside points
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pt_cnt  <= '0;
            grp_cnt <= '0;
            nb_cnt  <= '0;
            out_cnt <= '0;
        end else if (accept) begin
            pt_cnt  <= '0;
            grp_cnt <= '0;
            nb_cnt  <= '0;
            out_cnt <= '0;
        end else if (step) begin
            if (nb_last) begin
                nb_cnt  <= '0;
                out_cnt <= out_cnt + 1'b1;
                if (grp_last) begin
                    grp_cnt <= '0;
                    pt_cnt  <= pt_cnt + 1'b1;
                end else begin
                    grp_cnt <= grp_cnt + 1'b1;
                end
            end else begin
                nb_cnt <= nb_cnt + 1'b1;
            end
        end
    end

    // Map word for neighbor n of point p sits at p * 2**MAP_WIDTH + n
    assign map_rd_en   = step;
    assign map_rd_addr = (pt_cnt << MAP_WIDTH) | IDX_WIDTH'(nb_cnt);

    // ========================================
    // Feature read stage
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_s2   <= 1'b0;
            first_s2 <= 1'b0;
            last_s2  <= 1'b0;
        end else if (adv) begin
            vld_s2   <= step;
            first_s2 <= (nb_cnt == '0);
            last_s2  <= nb_last;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            grp_s2  <= grp_cnt;
            addr_s2 <= {job_last, out_cnt};
        end
    end

    assign ofm_rd_en   = vld_s2 & adv;
    assign ofm_rd_addr = IDX_WIDTH'(map_rd_dat * grp_num_q) + IDX_WIDTH'(grp_s2);

    // Job settings must describe a nonempty lane-aligned map
    a_cfg_legal: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (cfg_k != '0) && (cfg_k <= (MAP_WIDTH + 1)'(2 ** MAP_WIDTH))
                   && (cfg_nip != '0) && (cfg_chn != '0) && ((cfg_chn % LANES) == 0));

endmodule

// File: pool_core/pool_max.sv
`timescale 1ns/1ns

module pool_max import pool_pkg::*; #(
    parameter int ACT_WIDTH = pool_pkg::ACT_WIDTH,
    parameter int LANES     = pool_pkg::LANES,
    parameter int IDX_WIDTH = pool_pkg::IDX_WIDTH
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            adv,
    input  logic                            ofm_rd_en,
    input  logic                            first_s2,
    input  logic                            last_s2,
    input  logic [IDX_WIDTH+ATAG_WIDTH-1:0] addr_s2,
    input  logic [LANES*ACT_WIDTH-1:0]      ofm_rd_dat,
    output logic                            res_vld,
    output logic [LANES*ACT_WIDTH-1:0]      res_dat,
    output logic [IDX_WIDTH+ATAG_WIDTH-1:0] res_addr
);

    logic                            vld_s3;
    logic                            first_s3;
    logic                            last_s3;
    logic [IDX_WIDTH+ATAG_WIDTH-1:0] addr_s3;
    logic                            fold;
    logic                            grp_open;

    // Tags wait one cycle for the feature memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_s3   <= 1'b0;
            first_s3 <= 1'b0;
            last_s3  <= 1'b0;
            res_vld  <= 1'b0;
        end else if (adv) begin
            vld_s3   <= ofm_rd_en;
            first_s3 <= first_s2;
            last_s3  <= last_s2;
            res_vld  <= vld_s3 & last_s3;
        end
    end

    assign fold = vld_s3 & adv;

    always_ff @(posedge clk) begin
        if (adv) begin
            addr_s3 <= addr_s2;
        end
        if (fold) begin
            res_addr <= addr_s3;
        end
    end

    // ========================================
    // Lane compare array
    // ========================================

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [ACT_WIDTH-1:0] din;
        logic [ACT_WIDTH-1:0] max_q;

        assign din = ofm_rd_dat[i*ACT_WIDTH +: ACT_WIDTH];

        // First neighbor loads, later ones keep the larger
        always_ff @(posedge clk) begin
            if (fold && (first_s3 || din > max_q)) begin
                max_q <= din;
            end
        end

        assign res_dat[i*ACT_WIDTH +: ACT_WIDTH] = max_q;
    end

    // Set between the first and the last step of a group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grp_open <= 1'b0;
        end else if (fold) begin
            grp_open <= ~last_s3;
        end
    end

    // A group starts only after the previous one closed
    a_first_closed: assert property (@(posedge clk) disable iff (!rst_n)
        (fold && first_s3) |-> !grp_open);

    // Continuation steps belong to an open group
    a_next_open: assert property (@(posedge clk) disable iff (!rst_n)
        (fold && !first_s3) |-> grp_open);

endmodule

// File: pool_core/pool_wr.sv
`timescale 1ns/1ns

module pool_wr import pool_pkg::*; #(
    parameter int ACT_WIDTH = pool_pkg::ACT_WIDTH,
    parameter int LANES     = pool_pkg::LANES,
    parameter int IDX_WIDTH = pool_pkg::IDX_WIDTH
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            res_vld,
    input  logic [LANES*ACT_WIDTH-1:0]      res_dat,
    input  logic [IDX_WIDTH+ATAG_WIDTH-1:0] res_addr,
    input  logic                            wr_rdy,
    output logic                            wr_vld,
    output logic [IDX_WIDTH-1:0]            wr_addr,
    output logic [LANES*ACT_WIDTH-1:0]      wr_dat,
    output logic                            stall,
    output logic                            wr_done
);

    logic wr_fire;
    logic job_last;
    logic pend_q;

    // The result register in pool_max doubles as the output register
    assign wr_vld   = res_vld;
    assign wr_dat   = res_dat;
    assign wr_addr  = res_addr[IDX_WIDTH-1:0];
    assign job_last = res_addr[IDX_WIDTH+ATAG_WIDTH-1];

    assign wr_fire = wr_vld & wr_rdy;

    // Result offered but not taken holds the pipeline
    assign stall = wr_vld & ~wr_rdy;

    // Last result of the job accepted
    assign wr_done = wr_fire & job_last;

    // Remembers a result left pending across an edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= stall;
        end
    end

    // Pending write keeps its payload until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        pend_q |-> wr_vld && $stable(wr_dat) && $stable(wr_addr));

    // No second done pulse without a new job in between
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        wr_done |=> !wr_done);

endmodule

// File: design/pool_top.sv
`timescale 1ns/1ns

module pool_top import pool_pkg::*; #(
    parameter int ACT_WIDTH = pool_pkg::ACT_WIDTH,
    parameter int LANES     = pool_pkg::LANES,
    parameter int IDX_WIDTH = pool_pkg::IDX_WIDTH,
    parameter int MAP_WIDTH = pool_pkg::MAP_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    // Job configuration
    input  logic                         cfg_vld,
    output logic                         cfg_rdy,
    input  logic [MAP_WIDTH:0]           cfg_k,
    input  logic [IDX_WIDTH-1:0]         cfg_nip,
    input  logic [CHN_WIDTH-1:0]         cfg_chn,
    // Map memory
    output logic                         map_rd_en,
    output logic [IDX_WIDTH-1:0]         map_rd_addr,
    input  logic [IDX_WIDTH-1:0]         map_rd_dat,
    // Feature memory
    output logic                         ofm_rd_en,
    output logic [IDX_WIDTH-1:0]         ofm_rd_addr,
    input  logic [LANES*ACT_WIDTH-1:0]   ofm_rd_dat,
    // Pooled output
    output logic                         wr_vld,
    input  logic                         wr_rdy,
    output logic [IDX_WIDTH-1:0]         wr_addr,
    output logic [LANES*ACT_WIDTH-1:0]   wr_dat
);

    logic                          stall;
    logic                          adv;
    logic                          first_s2;
    logic                          last_s2;
    logic [IDX_WIDTH+ATAG_WIDTH-1:0] addr_s2;
    logic                          res_vld;
    logic [LANES*ACT_WIDTH-1:0]    res_dat;
    logic [IDX_WIDTH+ATAG_WIDTH-1:0] res_addr;
    logic                          wr_done;

    // Whole pipeline freezes while a write waits
    assign adv = ~stall;

    pool_seq #(
        .LANES     (LANES),
        .IDX_WIDTH (IDX_WIDTH),
        .MAP_WIDTH (MAP_WIDTH)
    ) u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .adv         (adv),
        .cfg_vld     (cfg_vld),
        .cfg_rdy     (cfg_rdy),
        .cfg_k       (cfg_k),
        .cfg_nip     (cfg_nip),
        .cfg_chn     (cfg_chn),
        .map_rd_en   (map_rd_en),
        .map_rd_addr (map_rd_addr),
        .map_rd_dat  (map_rd_dat),
        .ofm_rd_en   (ofm_rd_en),
        .ofm_rd_addr (ofm_rd_addr),
        .first_s2    (first_s2),
        .last_s2     (last_s2),
        .addr_s2     (addr_s2),
        .wr_done     (wr_done)
    );

    pool_max #(
        .ACT_WIDTH (ACT_WIDTH),
        .LANES     (LANES),
        .IDX_WIDTH (IDX_WIDTH)
    ) u_max (
        .clk        (clk),
        .rst_n      (rst_n),
        .adv        (adv),
        .ofm_rd_en  (ofm_rd_en),
        .first_s2   (first_s2),
        .last_s2    (last_s2),
        .addr_s2    (addr_s2),
        .ofm_rd_dat (ofm_rd_dat),
        .res_vld    (res_vld),
        .res_dat    (res_dat),
        .res_addr   (res_addr)
    );

    pool_wr #(
        .ACT_WIDTH (ACT_WIDTH),
        .LANES     (LANES),
        .IDX_WIDTH (IDX_WIDTH)
    ) u_wr (
        .clk      (clk),
        .rst_n    (rst_n),
        .res_vld  (res_vld),
        .res_dat  (res_dat),
        .res_addr (res_addr),
        .wr_rdy   (wr_rdy),
        .wr_vld   (wr_vld),
        .wr_addr  (wr_addr),
        .wr_dat   (wr_dat),
        .stall    (stall),
        .wr_done  (wr_done)
    );

endmodule

// File: sim/pool_tb.sv
`timescale 1ns/1ns

module pool_tb
    import pool_pkg::*;
();

    localparam int WORD_W     = LANES * ACT_WIDTH;
    localparam int MEM_DEPTH  = 1 << IDX_WIDTH;
    localparam int MAP_STRIDE = 1 << MAP_WIDTH;
    // Source points a map entry may name
    localparam int N_SRC      = 40;
    localparam int TIMEOUT    = 5000;

    logic                   clk;
    logic                   rst_n;
    logic                   cfg_vld;
    logic                   cfg_rdy;
    logic [MAP_WIDTH:0]     cfg_k;
    logic [IDX_WIDTH-1:0]   cfg_nip;
    logic [CHN_WIDTH-1:0]   cfg_chn;
    logic                   map_rd_en;
    logic [IDX_WIDTH-1:0]   map_rd_addr;
    logic [IDX_WIDTH-1:0]   map_rd_dat;
    logic                   ofm_rd_en;
    logic [IDX_WIDTH-1:0]   ofm_rd_addr;
    logic [WORD_W-1:0]      ofm_rd_dat;
    logic                   wr_vld;
    logic                   wr_rdy;
    logic [IDX_WIDTH-1:0]   wr_addr;
    logic [WORD_W-1:0]      wr_dat;

    logic [IDX_WIDTH-1:0]   map_mem [MEM_DEPTH];
    logic [WORD_W-1:0]      ofm_mem [MEM_DEPTH];

    // Expected writes in loop order
    logic [IDX_WIDTH-1:0]   exp_addr [$];
    logic [WORD_W-1:0]      exp_dat [$];

    int                     cur_k;
    int                     cur_groups;
    bit                     rdy_rand;
    bit                     aborted;
    int                     ctl_errors;
    int                     wr_errors;

    bit                     held_vld;
    logic [IDX_WIDTH-1:0]   held_addr;
    logic [WORD_W-1:0]      held_dat;
    logic [IDX_WIDTH-1:0]   want_addr;
    logic [WORD_W-1:0]      want_dat;

    pool_top #(
        .ACT_WIDTH (ACT_WIDTH),
        .LANES     (LANES),
        .IDX_WIDTH (IDX_WIDTH),
        .MAP_WIDTH (MAP_WIDTH)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_vld     (cfg_vld),
        .cfg_rdy     (cfg_rdy),
        .cfg_k       (cfg_k),
        .cfg_nip     (cfg_nip),
        .cfg_chn     (cfg_chn),
        .map_rd_en   (map_rd_en),
        .map_rd_addr (map_rd_addr),
        .map_rd_dat  (map_rd_dat),
        .ofm_rd_en   (ofm_rd_en),
        .ofm_rd_addr (ofm_rd_addr),
        .ofm_rd_dat  (ofm_rd_dat),
        .wr_vld      (wr_vld),
        .wr_rdy      (wr_rdy),
        .wr_addr     (wr_addr),
        .wr_dat      (wr_dat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Memory models and output sink
    // ========================================

    // Read data lands one cycle after the strobe and holds until the next
    initial begin
        map_rd_dat = '0;
        ofm_rd_dat = '0;
        forever begin
            @(posedge clk);
            if (map_rd_en) begin
                map_rd_dat <= map_mem[map_rd_addr];
            end
            if (ofm_rd_en) begin
                ofm_rd_dat <= ofm_mem[ofm_rd_addr];
            end
        end
    end

    initial begin
        wr_rdy = 1'b1;
        forever begin
            @(posedge clk);
            if (rdy_rand) begin
                wr_rdy <= ($urandom_range(0, 1) != 0);
            end else begin
                wr_rdy <= 1'b1;
            end
        end
    end

    // Lane-wise unsigned maximum over all neighbors of one point and group
    function automatic logic [WORD_W-1:0] pool_ref(input int point, input int group);
        logic [WORD_W-1:0] acc;
        logic [WORD_W-1:0] word;
        int                idx;
        acc = '0;
        for (int n = 0; n < cur_k; n++) begin
            idx  = int'(map_mem[IDX_WIDTH'(point * MAP_STRIDE + n)]);
            word = ofm_mem[IDX_WIDTH'(idx * cur_groups + group)];
            for (int l = 0; l < LANES; l++) begin
                if (word[l*ACT_WIDTH +: ACT_WIDTH] > acc[l*ACT_WIDTH +: ACT_WIDTH]) begin
                    acc[l*ACT_WIDTH +: ACT_WIDTH] = word[l*ACT_WIDTH +: ACT_WIDTH];
                end
            end
        end
        return acc;
    endfunction

    task automatic fill_mems(input int k, input int nip, input int groups);
        logic [WORD_W-1:0] word;
        for (int p = 0; p < nip; p++) begin
            for (int n = 0; n < k; n++) begin
                map_mem[IDX_WIDTH'(p * MAP_STRIDE + n)] = IDX_WIDTH'($urandom_range(0, N_SRC - 1));
            end
        end
        for (int a = 0; a < N_SRC * groups; a++) begin
            for (int l = 0; l < LANES; l++) begin
                word[l*ACT_WIDTH +: ACT_WIDTH] = ACT_WIDTH'($urandom());
            end
            ofm_mem[IDX_WIDTH'(a)] = word;
        end
    endtask

    // Idle outputs sampled mid-cycle
    task automatic check_quiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (cfg_rdy !== 1'b1) begin
                ctl_errors++;
                $display("Fail t=%0t cfg_rdy got %b exp 1", $time, cfg_rdy);
            end
            if (map_rd_en !== 1'b0) begin
                ctl_errors++;
                $display("Fail t=%0t map_rd_en got %b exp 0", $time, map_rd_en);
            end
            if (ofm_rd_en !== 1'b0) begin
                ctl_errors++;
                $display("Fail t=%0t ofm_rd_en got %b exp 0", $time, ofm_rd_en);
            end
            if (wr_vld !== 1'b0) begin
                ctl_errors++;
                $display("Fail t=%0t wr_vld got %b exp 0", $time, wr_vld);
            end
        end
    endtask

    // ========================================
    // Job runner
    // ========================================

    task automatic run_job(input int k, input int nip, input int chn, input bit rand_rdy);
        int groups;
        int cycles;
        groups     = chn / LANES;
        cur_k      = k;
        cur_groups = groups;
        rdy_rand   = rand_rdy;
        fill_mems(k, nip, groups);
        for (int p = 0; p < nip; p++) begin
            for (int g = 0; g < groups; g++) begin
                exp_addr.push_back(IDX_WIDTH'(p * groups + g));
                exp_dat.push_back(pool_ref(p, g));
            end
        end

        cycles = 0;
        while (cfg_rdy !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cfg_rdy !== 1'b1) begin
            ctl_errors++;
            $display("Timed out at %0t waiting for cfg_rdy before a new job", $time);
            aborted = 1'b1;
            return;
        end

        @(posedge clk);
        cfg_vld <= 1'b1;
        cfg_k   <= (MAP_WIDTH + 1)'(k);
        cfg_nip <= IDX_WIDTH'(nip);
        cfg_chn <= CHN_WIDTH'(chn);
        @(posedge clk);
        cfg_vld <= 1'b0;

        // cfg_rdy must stay low while results are outstanding
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (exp_addr.size() != 0 && cfg_rdy !== 1'b0) begin
                ctl_errors++;
                $display("Fail t=%0t cfg_rdy got %b exp 0", $time, cfg_rdy);
            end
        end
        if (exp_addr.size() != 0) begin
            ctl_errors++;
            $display("Timed out at %0t with %0d results of the job never written",
                     $time, exp_addr.size());
            exp_addr.delete();
            exp_dat.delete();
            aborted = 1'b1;
            return;
        end

        // Ready again in the cycle after the last write was taken
        if (cfg_rdy !== 1'b1) begin
            ctl_errors++;
            $display("Fail t=%0t cfg_rdy got %b exp 1", $time, cfg_rdy);
            aborted = 1'b1;
        end
    endtask

    // ========================================
    // Write checker
    // ========================================

    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            // Payload frozen while a write waits
            if (held_vld) begin
                if (wr_vld !== 1'b1) begin
                    wr_errors++;
                    $display("Fail t=%0t wr_vld got %b exp 1", $time, wr_vld);
                end
                if (wr_addr !== held_addr) begin
                    wr_errors++;
                    $display("Fail t=%0t wr_addr got %h exp %h", $time, wr_addr, held_addr);
                end
                if (wr_dat !== held_dat) begin
                    wr_errors++;
                    $display("Fail t=%0t wr_dat got %h exp %h", $time, wr_dat, held_dat);
                end
            end
            if (wr_vld === 1'b1 && wr_rdy === 1'b1) begin
                if (exp_addr.size() == 0) begin
                    wr_errors++;
                    $display("Write to %h accepted at %0t with no result outstanding",
                             wr_addr, $time);
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_dat  = exp_dat.pop_front();
                    if (wr_addr !== want_addr) begin
                        wr_errors++;
                        $display("Fail t=%0t wr_addr got %h exp %h", $time, wr_addr, want_addr);
                    end
                    if (wr_dat !== want_dat) begin
                        wr_errors++;
                        $display("Fail t=%0t wr_dat got %h exp %h", $time, wr_dat, want_dat);
                    end
                end
            end
            held_vld  = (wr_vld === 1'b1) && (wr_rdy !== 1'b1);
            held_addr = wr_addr;
            held_dat  = wr_dat;
        end
    end

    initial begin
        void'($urandom(32'h8de5_64d5));
        rst_n   = 1'b0;
        cfg_vld = 1'b0;
        cfg_k   = '0;
        cfg_nip = '0;
        cfg_chn = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        check_quiet(2);
        run_job(5, 6, 24, 1'b0);
        if (!aborted) begin
            run_job(7, 5, 16, 1'b1);
        end
        if (!aborted) begin
            run_job(1, 4, 32, 1'b1);
        end
        // Full neighbor range
        if (!aborted) begin
            run_job(32, 2, 8, 1'b0);
        end
        if (!aborted) begin
            check_quiet(4);
        end

        $display("errors: control=%0d write=%0d", ctl_errors, wr_errors);
        if (ctl_errors + wr_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: list.f
common/pool_pkg.sv
pool_core/pool_seq.sv
pool_core/pool_max.sv
pool_core/pool_wr.sv
design/pool_top.sv
sim/pool_tb.sv

// File: Bender.yml
package:
  name: pool_engine

sources:
  # Shared package first
  - common/pool_pkg.sv
  # Pooling stages
  - pool_core/pool_seq.sv
  - pool_core/pool_max.sv
  - pool_core/pool_wr.sv
  # Top level
  - design/pool_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/pool_tb.sv
